// File: hdl/dsiq_pkg.sv
`default_nettype none

package dsiq_pkg;

  // byte stream in
  localparam int wr_width = 8;

  // packed words out, first byte in the low lane
  localparam int rd_width = 32;

  // bytes per read word
  localparam int ratio = rd_width / wr_width;

  // status byte is {recovery flag, scaled fill}
  localparam int count_width = 7;
  localparam int status_width = count_width + 1;

endpackage

`default_nettype wire

// File: hdl/gray_sync.sv
`timescale 1ns/10ps
`default_nettype none

module gray_sync #(
  parameter int width = 4
) (
  input  logic             src_clk,
  input  logic             dst_clk,
  input  logic             arst_n,
  input  logic [width-1:0] src_bin,
  output logic [width-1:0] dst_bin
);

  logic [width-1:0] src_gray;
  logic [width-1:0] sync_1;
  logic [width-1:0] sync_2;

  function automatic logic [width-1:0] gray_to_bin(input logic [width-1:0] g);
    logic [width-1:0] b;
    b[width-1] = g[width-1];
    for (int i = width - 2; i >= 0; i--) begin
      b[i] = b[i+1] ^ g[i];
    end
    return b;
  endfunction

  // registered so only one bit moves per pointer step
  always_ff @(posedge src_clk or negedge arst_n) begin
    if (!arst_n) begin
      src_gray <= '0;
    end else begin
      src_gray <= src_bin ^ (src_bin >> 1);
    end
  end

  always_ff @(posedge dst_clk or negedge arst_n) begin
    if (!arst_n) begin
      sync_1  <= '0;
      sync_2  <= '0;
      dst_bin <= '0;
    end else begin
      sync_1  <= src_gray;
      sync_2  <= sync_1;
      dst_bin <= gray_to_bin(sync_2);
    end
  end

endmodule

`default_nettype wire

// File: hdl/async_fifo_mixed.sv
`timescale 1ns/10ps
`default_nettype none

module async_fifo_mixed #(
  parameter  int depth   = 8192,
  localparam int wr_bits = $clog2(depth) + 1,
  localparam int rd_bits = $clog2(depth / dsiq_pkg::ratio) + 1
) (
  input  logic                          wr_clk,
  input  logic                          rd_clk,
  input  logic                          arst_n,

  input  logic                          wr_en,
  input  logic [dsiq_pkg::wr_width-1:0] wr_data,
  output logic                          wr_full,
  output logic [wr_bits-1:0]            wr_used,

  input  logic                          rd_en,
  output logic                          rd_empty,
  output logic [rd_bits-1:0]            rd_used,
  output logic [dsiq_pkg::rd_width-1:0] rd_data
);

  localparam int words     = depth / dsiq_pkg::ratio;
  localparam int lane_bits = $clog2(dsiq_pkg::ratio);

  logic [dsiq_pkg::rd_width-1:0] mem [words];

  // write side, pointer counts bytes
  logic [wr_bits-1:0]         wr_ptr;
  logic [wr_bits-1:0]         wr_ptr_next;
  logic [wr_bits-1:0]         wr_used_next;
  logic [rd_bits-1:0]         rd_ptr_wr;
  logic [wr_bits-1:0]         rd_ptr_bytes;
  logic [rd_bits-2:0]         wr_addr;
  logic [lane_bits-1:0]       wr_lane;
  logic                       wr_ok;

  // read side, pointer counts words
  logic [rd_bits-1:0]         rd_ptr;
  logic [wr_bits-1:0]         wr_ptr_rd;
  logic [rd_bits-1:0]         wr_words;
  logic                       rd_ok;

  assign wr_ok        = wr_en & ~wr_full;
  assign wr_ptr_next  = wr_ptr + wr_bits'(wr_ok);
  assign rd_ptr_bytes = {rd_ptr_wr, {lane_bits{1'b0}}};
  assign wr_used_next = wr_ptr_next - rd_ptr_bytes;

  assign wr_addr = wr_ptr[wr_bits-2:lane_bits];
  assign wr_lane = wr_ptr[lane_bits-1:0];

  // full is held through reset so nothing lands before the pointers settle
  always_ff @(posedge wr_clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr  <= '0;
      wr_used <= '0;
      wr_full <= 1'b1;
    end else begin
      wr_ptr  <= wr_ptr_next;
      wr_used <= wr_used_next;
      wr_full <= (wr_used_next == wr_bits'(depth));
    end
  end

  // one byte lane per write
  always_ff @(posedge wr_clk) begin
    if (wr_ok) begin
      mem[wr_addr][wr_lane*dsiq_pkg::wr_width +: dsiq_pkg::wr_width] <= wr_data;
    end
  end

  gray_sync #(
    .width(wr_bits)
  ) wr_ptr_sync (
    .src_clk (wr_clk),
    .dst_clk (rd_clk),
    .arst_n  (arst_n),
    .src_bin (wr_ptr),
    .dst_bin (wr_ptr_rd)
  );

  gray_sync #(
    .width(rd_bits)
  ) rd_ptr_sync (
    .src_clk (rd_clk),
    .dst_clk (wr_clk),
    .arst_n  (arst_n),
    .src_bin (rd_ptr),
    .dst_bin (rd_ptr_wr)
  );

  // a word counts only once all of its bytes are in
  assign wr_words = wr_ptr_rd[wr_bits-1:lane_bits];
  assign rd_used  = wr_words - rd_ptr;
  assign rd_empty = (rd_used == '0);
  assign rd_ok    = rd_en & ~rd_empty;

  // show-ahead head word
  assign rd_data = mem[rd_ptr[rd_bits-2:0]];

  always_ff @(posedge rd_clk or negedge arst_n) begin
    if (!arst_n) begin
      rd_ptr <= '0;
    end else begin
      rd_ptr <= rd_ptr + rd_bits'(rd_ok);
    end
  end

  wr_no_overflow: assert property (
    @(posedge wr_clk) disable iff (!arst_n)
    wr_en |-> !wr_full
  ) else $error("write request while FIFO full");

  rd_no_underflow: assert property (
    @(posedge rd_clk) disable iff (!arst_n)
    rd_en |-> !rd_empty
  ) else $error("read request while FIFO empty");

  // synced write pointer never runs ahead of capacity
  rd_fill_bound: assert property (
    @(posedge rd_clk) disable iff (!arst_n)
    rd_used <= rd_bits'(words)
  ) else $error("read side fill %0d beyond capacity", rd_used);

endmodule

`default_nettype wire

// File: hdl/dsiq_buffer.sv
`timescale 1ns/10ps
`default_nettype none

module dsiq_buffer #(
  parameter int depth = 8192
) (
  input  logic                              wr_clk,
  input  logic                              rd_clk,
  input  logic                              arst_n,

  input  logic [dsiq_pkg::wr_width-1:0]     wr_tdata,
  input  logic                              wr_tvalid,
  input  logic                              wr_tlast,
  output logic                              wr_tready,

  output logic [dsiq_pkg::rd_width-1:0]     rd_tdata,
  output logic                              rd_tvalid,
  input  logic                              rd_tready,

  input  logic                              rd_sample,
  output logic [dsiq_pkg::status_width-1:0] rd_status
);

  localparam int wr_bits    = $clog2(depth) + 1;
  localparam int rd_bits    = $clog2(depth / dsiq_pkg::ratio) + 1;
  localparam int push_limit = depth / 2;
  localparam int pop_limit  = depth / (2 * dsiq_pkg::ratio);
  localparam int count_lsb  = rd_bits - dsiq_pkg::count_width;

  logic                                 fifo_wr_en;
  logic                                 wr_full;
  logic [wr_bits-1:0]                   wr_used;
  logic                                 fifo_rd_en;
  logic                                 rd_empty;
  logic [rd_bits-1:0]                   rd_used;
  logic [dsiq_pkg::rd_width-1:0]        fifo_data;

  logic                                 allow_push;
  logic                                 allow_pop;
  logic [dsiq_pkg::count_width-1:0]     count_next;
  logic [dsiq_pkg::count_width-1:0]     rd_count;
  logic                                 recovery_flag;
  logic                                 recovery_flag_d1;

  // write side reopens only on a packet end at half fill or less
  // full is also held through reset while the FIFO holds no bytes
  always_ff @(posedge wr_clk or negedge arst_n) begin
    if (!arst_n) begin
      allow_push <= 1'b1;
    end else if (wr_full && wr_used[wr_bits-1]) begin
      allow_push <= 1'b0;
    end else if (wr_tlast && (wr_used <= wr_bits'(push_limit))) begin
      allow_push <= 1'b1;
    end
  end

  assign wr_tready  = ~wr_full & allow_push;
  assign fifo_wr_en = wr_tvalid & wr_tready;

  async_fifo_mixed #(
    .depth(depth)
  ) fifo_i (
    .wr_clk   (wr_clk),
    .rd_clk   (rd_clk),
    .arst_n   (arst_n),
    .wr_en    (fifo_wr_en),
    .wr_data  (wr_tdata),
    .wr_full  (wr_full),
    .wr_used  (wr_used),
    .rd_en    (fifo_rd_en),
    .rd_empty (rd_empty),
    .rd_used  (rd_used),
    .rd_data  (fifo_data)
  );

  // read side waits for half the word capacity after running dry
  always_ff @(posedge rd_clk or negedge arst_n) begin
    if (!arst_n) begin
      allow_pop <= 1'b0;
    end else if (rd_empty) begin
      allow_pop <= 1'b0;
    end else if (rd_used >= rd_bits'(pop_limit)) begin
      allow_pop <= 1'b1;
    end
  end

  assign rd_tvalid  = ~rd_empty & allow_pop;
  assign fifo_rd_en = rd_tready & rd_tvalid;
  assign rd_tdata   = rd_tvalid ? fifo_data : '0;

  // count takes the top bits of the word fill and saturates when completely full
  assign count_next = rd_used[rd_bits-1] ? '1 : rd_used[rd_bits-1:count_lsb];

  // allow_push enters unsynchronized and only feeds the status flag
  always_ff @(posedge rd_clk or negedge arst_n) begin
    if (!arst_n) begin
      rd_count         <= '0;
      recovery_flag    <= 1'b0;
      recovery_flag_d1 <= 1'b0;
    end else if (rd_sample) begin
      rd_count         <= count_next;
      recovery_flag    <= 1'b0;
      recovery_flag_d1 <= recovery_flag;
    end else if (!allow_pop || !allow_push) begin
      recovery_flag    <= 1'b1;
    end
  end

  assign rd_status = {recovery_flag_d1, rd_count};

  // head word stays offered until it is taken
  rd_held_until_taken: assert property (
    @(posedge rd_clk) disable iff (!arst_n)
    (rd_tvalid && !rd_tready) |=> (rd_tvalid && $stable(rd_tdata))
  ) else $error("rd_tvalid or rd_tdata changed before the word was taken");

endmodule

`default_nettype wire

// File: hdl/dsiq_top.sv
`timescale 1ns/10ps
`default_nettype none

module dsiq_top #(
  parameter int depth = 8192
) (
  input  logic                              wr_clk,
  input  logic                              rd_clk,
  input  logic                              arst_n,

  input  logic [dsiq_pkg::wr_width-1:0]     wr_tdata,
  input  logic                              wr_tvalid,
  input  logic                              wr_tlast,
  output logic                              wr_tready,

  output logic [dsiq_pkg::rd_width-1:0]     rd_tdata,
  output logic                              rd_tvalid,
  input  logic                              rd_tready,

  input  logic                              rd_sample,
  output logic [dsiq_pkg::status_width-1:0] rd_status
);

  // downstream iq buffer, bytes in on wr_clk, words out on rd_clk
  dsiq_buffer #(
    .depth(depth)
  ) buffer_i (
    .wr_clk    (wr_clk),
    .rd_clk    (rd_clk),
    .arst_n    (arst_n),
    .wr_tdata  (wr_tdata),
    .wr_tvalid (wr_tvalid),
    .wr_tlast  (wr_tlast),
    .wr_tready (wr_tready),
    .rd_tdata  (rd_tdata),
    .rd_tvalid (rd_tvalid),
    .rd_tready (rd_tready),
    .rd_sample (rd_sample),
    .rd_status (rd_status)
  );

endmodule

`default_nettype wire

// File: dv/dsiq_checker.sv
`timescale 1ns/10ps
`default_nettype none

module dsiq_checker #(
  parameter int depth = 512
) (
  input  logic                              wr_clk,
  input  logic                              rd_clk,
  input  logic                              arst_n,
  input  logic [dsiq_pkg::wr_width-1:0]     wr_tdata,
  input  logic                              wr_tvalid,
  input  logic                              wr_tlast,
  input  logic                              wr_tready,
  input  logic [dsiq_pkg::rd_width-1:0]     rd_tdata,
  input  logic                              rd_tvalid,
  input  logic                              rd_tready,
  input  logic                              rd_sample,
  input  logic [dsiq_pkg::status_width-1:0] rd_status,
  input  logic [2:0]                        phase
);

  localparam int ratio       = dsiq_pkg::ratio;
  localparam int wr_width    = dsiq_pkg::wr_width;
  localparam int count_width = dsiq_pkg::count_width;
  localparam int words       = depth / ratio;
  localparam int count_shift = $clog2(words) + 1 - count_width;
  localparam int pop_limit   = words / 2;

  // bytes accepted on the write side and not yet read out
  logic [wr_width-1:0] byte_q [$];

  int accepted_bytes = 0;
  int consumed_words = 0;
  int data_errs      = 0;
  int hyst_errs      = 0;
  int status_errs    = 0;
  int samples        = 0;
  int pending        = 0;

  logic                   prev_ready    = 1'b0;
  logic                   prev_tlast    = 1'b0;
  logic                   ready_seen    = 1'b0;
  logic                   prev_rd_valid = 1'b0;
  logic [count_width-1:0] exp_count     = '0;

  // status count is the word fill scaled to 7 bits, pinned when full
  function automatic logic [count_width-1:0] scale_fill(input int fill);
    if (fill >= words) begin
      return '1;
    end
    return count_width'(fill >> count_shift);
  endfunction

  always @(posedge wr_clk) begin
    if (!arst_n) begin
      prev_ready = 1'b0;
      prev_tlast = 1'b0;
      ready_seen = 1'b0;
    end else begin
      if (wr_tvalid && wr_tready) begin
        byte_q.push_back(wr_tdata);
        accepted_bytes++;
      end
      if (ready_seen && !prev_ready && wr_tready && !prev_tlast) begin
        $display("wr_tready reopened at %0t without a packet end in the cycle before", $time);
        hyst_errs++;
      end
      // full hold after the fill
      if (phase == 3'd2 && wr_tready !== 1'b0) begin
        $display("ERR fill_ready expected 0 actual %b", wr_tready);
        hyst_errs++;
      end
      prev_ready = wr_tready;
      prev_tlast = wr_tlast;
      if (wr_tready) begin
        ready_seen = 1'b1;
      end
    end
  end

  always @(posedge rd_clk) begin : rd_side
    int fill;
    logic [dsiq_pkg::rd_width-1:0] exp_word;
    if (!arst_n) begin
      prev_rd_valid = 1'b0;
    end else begin
      fill = accepted_bytes / ratio - consumed_words;

      if (samples == 0 && rd_status !== '0) begin
        $display("ERR status_reset expected %h actual %h", 8'h00, rd_status);
        status_errs++;
      end
      // the cycle after a sample shows the captured values
      if (pending != 0) begin
        if (rd_status[count_width-1:0] !== exp_count) begin
          $display("ERR status_count expected %h actual %h",
                   exp_count, rd_status[count_width-1:0]);
          status_errs++;
        end
        if (pending == 2 && rd_status[count_width] !== 1'b1) begin
          $display("ERR status_flag expected 1 actual %b", rd_status[count_width]);
          status_errs++;
        end
        pending = 0;
      end
      if (rd_sample) begin
        samples++;
        exp_count = scale_fill(fill);
        if (samples <= 2) begin
          pending = samples;
        end
      end

      if (!rd_tvalid && rd_tdata !== '0) begin
        $display("ERR zero_withheld expected %h actual %h",
                 {dsiq_pkg::rd_width{1'b0}}, rd_tdata);
        data_errs++;
      end
      if (rd_tvalid && !prev_rd_valid && fill < pop_limit) begin
        $display("rd_tvalid rose at %0t with only %0d words buffered", $time, fill);
        hyst_errs++;
      end

      if (rd_tvalid && rd_tready) begin
        if (byte_q.size() < ratio) begin
          $display("word read at %0t with fewer than four bytes accepted", $time);
          data_errs++;
        end else begin
          for (int i = 0; i < ratio; i++) begin
            exp_word[i*wr_width +: wr_width] = byte_q.pop_front();
          end
          if (rd_tdata !== exp_word) begin
            $display("ERR order word %0d expected %h actual %h",
                     consumed_words, exp_word, rd_tdata);
            data_errs++;
          end
        end
        consumed_words++;
      end
      prev_rd_valid = rd_tvalid;
    end
  end

endmodule

`default_nettype wire

// File: dv/dsiq_tb.sv
`timescale 1ns/10ps
`default_nettype none

module dsiq_tb;

  localparam int depth          = 512;
  localparam int fill_limit     = 4 * depth;
  localparam int drain_limit    = 4000;
  localparam int traffic_cycles = 8000;

  logic                              wr_clk = 1'b0;
  logic                              rd_clk = 1'b0;
  logic                              arst_n;
  logic [dsiq_pkg::wr_width-1:0]     wr_tdata;
  logic                              wr_tvalid;
  logic                              wr_tlast;
  logic                              wr_tready;
  logic [dsiq_pkg::rd_width-1:0]     rd_tdata;
  logic                              rd_tvalid;
  logic                              rd_tready;
  logic                              rd_sample;
  logic [dsiq_pkg::status_width-1:0] rd_status;

  // 1 fill, 2 full hold, 3 traffic, 4 drain, 5 quiet
  logic [2:0] phase;
  // reader 0 stopped, 1 slow and fast runs, 2 always ready
  logic [1:0] rd_mode;
  logic       rd_slow;
  logic       burst_on;
  int         rd_run_left;
  int         burst_left;
  int         pkt_left;
  int         other_errs;

  always #50 wr_clk = ~wr_clk;

  // edges never line up with wr_clk
  always #65 rd_clk = ~rd_clk;

  dsiq_top #(
    .depth(depth)
  ) uut (
    .wr_clk    (wr_clk),
    .rd_clk    (rd_clk),
    .arst_n    (arst_n),
    .wr_tdata  (wr_tdata),
    .wr_tvalid (wr_tvalid),
    .wr_tlast  (wr_tlast),
    .wr_tready (wr_tready),
    .rd_tdata  (rd_tdata),
    .rd_tvalid (rd_tvalid),
    .rd_tready (rd_tready),
    .rd_sample (rd_sample),
    .rd_status (rd_status)
  );

  dsiq_checker #(
    .depth(depth)
  ) chk (
    .wr_clk    (wr_clk),
    .rd_clk    (rd_clk),
    .arst_n    (arst_n),
    .wr_tdata  (wr_tdata),
    .wr_tvalid (wr_tvalid),
    .wr_tlast  (wr_tlast),
    .wr_tready (wr_tready),
    .rd_tdata  (rd_tdata),
    .rd_tvalid (rd_tvalid),
    .rd_tready (rd_tready),
    .rd_sample (rd_sample),
    .rd_status (rd_status),
    .phase     (phase)
  );

  // slow runs fill the FIFO, fast runs drain it
  always @(posedge rd_clk) begin
    case (rd_mode)
      2'd1: begin
        if (rd_run_left == 0) begin
          rd_slow = ~rd_slow;
          rd_run_left = rd_slow ? 800 + $urandom % 800 : 200 + $urandom % 400;
        end
        rd_run_left--;
        rd_tready <= rd_slow ? ($urandom % 16 == 0) : ($urandom % 4 != 0);
      end
      2'd2: rd_tready <= 1'b1;
      default: rd_tready <= 1'b0;
    endcase
  end

  // refused bytes are dropped, the packet moves on anyway
  task automatic send_byte(input logic valid);
    wr_tdata <= 8'($urandom);
    if (valid) begin
      if (pkt_left == 0) begin
        pkt_left = 1 + $urandom % 48;
      end
      wr_tvalid <= 1'b1;
      wr_tlast  <= (pkt_left == 1);
      pkt_left--;
    end else begin
      wr_tvalid <= 1'b0;
      wr_tlast  <= 1'b0;
    end
  endtask

  task automatic drive_stream(input int cycles, input logic bursty);
    for (int n = 0; n < cycles; n++) begin
      @(posedge wr_clk);
      if (bursty) begin
        if (burst_left == 0) begin
          burst_on = ($urandom % 100) < 70;
          burst_left = 1 + $urandom % 24;
        end
        burst_left--;
        send_byte(burst_on);
      end else begin
        send_byte(1'b1);
      end
    end
  endtask

  task automatic fill_until_refused(input int limit);
    int   waited;
    logic seen_ready;
    logic refused;
    waited = 0;
    seen_ready = 1'b0;
    refused = 1'b0;
    while (!refused && waited < limit) begin
      @(posedge wr_clk);
      waited++;
      if (wr_tready) begin
        seen_ready = 1'b1;
      end else if (seen_ready) begin
        refused = 1'b1;
      end
      send_byte(1'b1);
    end
    if (!refused) begin
      $display("timeout: wr_tready never dropped within %0d wr_clk cycles of filling", limit);
      other_errs++;
    end
  endtask

  task automatic idle_writer();
    @(posedge wr_clk);
    send_byte(1'b0);
  endtask

  task automatic wait_drained(input int limit);
    int waited;
    int low_run;
    waited = 0;
    low_run = 0;
    while (low_run < 16 && waited < limit) begin
      @(posedge rd_clk);
      waited++;
      if (rd_tvalid) begin
        low_run = 0;
      end else begin
        low_run++;
      end
    end
    if (low_run < 16) begin
      $display("timeout: read side still valid after %0d rd_clk cycles of draining", limit);
      other_errs++;
    end
  endtask

  task automatic pulse_sample();
    @(posedge rd_clk);
    rd_sample <= 1'b1;
    @(posedge rd_clk);
    rd_sample <= 1'b0;
  endtask

  initial begin : main
    int total;
    void'($urandom(32'hc372_98f8));
    arst_n      = 1'b0;
    wr_tdata    = '0;
    wr_tvalid   = 1'b0;
    wr_tlast    = 1'b0;
    rd_tready   = 1'b0;
    rd_sample   = 1'b0;
    phase       = 3'd0;
    rd_mode     = 2'd0;
    rd_slow     = 1'b1;
    burst_on    = 1'b0;
    rd_run_left = 0;
    burst_left  = 0;
    pkt_left    = 0;
    other_errs  = 0;

    repeat (16) @(posedge rd_clk);
    arst_n <= 1'b1;
    repeat (4) @(posedge wr_clk);

    phase <= 3'd1;
    fill_until_refused(fill_limit);
    phase <= 3'd2;
    drive_stream(50, 1'b0);

    phase   <= 3'd3;
    rd_mode <= 2'd1;
    drive_stream(traffic_cycles, 1'b1);

    phase   <= 3'd4;
    rd_mode <= 2'd2;
    idle_writer();
    wait_drained(drain_limit);

    // both sides stopped before sampling status
    @(posedge rd_clk);
    phase   <= 3'd5;
    rd_mode <= 2'd0;
    repeat (10) @(posedge rd_clk);
    pulse_sample();
    repeat (4) @(posedge rd_clk);
    pulse_sample();
    repeat (4) @(posedge rd_clk);

    if (chk.consumed_words == 0) begin
      $display("no words were read during the run");
      other_errs++;
    end
    if (chk.samples != 2) begin
      $display("status was sampled %0d times instead of twice", chk.samples);
      other_errs++;
    end
    $display("bytes accepted %0d, words read %0d", chk.accepted_bytes, chk.consumed_words);
    total = chk.data_errs + chk.hyst_errs + chk.status_errs + other_errs;
    $display("errors: data %0d, hysteresis %0d, status %0d, other %0d",
             chk.data_errs, chk.hyst_errs, chk.status_errs, other_errs);
    if (total == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: flist.f
hdl/dsiq_pkg.sv
hdl/gray_sync.sv
hdl/async_fifo_mixed.sv
hdl/dsiq_buffer.sv
hdl/dsiq_top.sv
dv/dsiq_checker.sv
dv/dsiq_tb.sv

// File: Makefile
# Verilator flow for the downstream IQ buffer testbench

VERILATOR ?= verilator
TOP       ?= dsiq_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_TEXT ?= All tests passed
JOBS      ?= 0
VFLAGS    ?= --timing --assert --timescale 1ns/10ps

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FLIST)

build:
	$(VERILATOR) --binary $(VFLAGS) -j $(JOBS) --top-module $(TOP) \
		-Mdir $(OBJ_DIR) -f $(FLIST)

sim: build
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
